/* design/fixed_round.sv */
`include "vecdot_macros.svh"

module fixed_round (
  input  logic                clk,
  input  logic                reset,
  input  logic                en,
  input  vecdot_pkg::acc_t    acc,
  input  logic                acc_valid,
  output vecdot_pkg::sample_t dout,
  output logic                dout_valid,
  output logic                sat
);

  // Bits from the output sign bit up to the accumulator sign bit
  localparam int UPPER_WIDTH = `VD_ACC_WIDTH - `VD_IN_WIDTH + 1;

  vecdot_pkg::acc_t    rounded;
  vecdot_pkg::acc_t    shifted;
  logic [UPPER_WIDTH-1:0] upper;
  logic                pos_ovf;
  logic                neg_ovf;
  vecdot_pkg::sample_t clamped;
  vecdot_pkg::sample_t dout_q;
  logic                valid_q;
  logic                sat_q;

  // Round half up, then drop 10 of the 20 fraction bits
  assign rounded = acc + vecdot_pkg::acc_t'(1 << (`VD_IN_FRAC - 1));
  assign shifted = rounded >>> `VD_IN_FRAC;

  // Out of range unless all upper bits match the sign
  assign upper   = shifted[`VD_ACC_WIDTH-1:`VD_IN_WIDTH-1];
  assign pos_ovf = !upper[UPPER_WIDTH-1] && (|upper);
  assign neg_ovf = upper[UPPER_WIDTH-1] && !(&upper);

  always_comb begin
    if (pos_ovf) begin
      clamped = {1'b0, {(`VD_IN_WIDTH-1){1'b1}}};
    end else if (neg_ovf) begin
      clamped = {1'b1, {(`VD_IN_WIDTH-1){1'b0}}};
    end else begin
      clamped = shifted[`VD_IN_WIDTH-1:0];
    end
  end

  //////////////////////////////////////////////////
  // Output register
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      dout_q  <= '0;
      valid_q <= 1'b0;
      sat_q   <= 1'b0;
    end else if (en) begin
      valid_q <= acc_valid;
      sat_q   <= acc_valid && (pos_ovf || neg_ovf);
      // dout keeps the last result between valid pulses
      if (acc_valid) begin
        dout_q <= clamped;
      end
    end
  end

  assign dout       = dout_q;
  assign dout_valid = valid_q;
  assign sat        = sat_q;

endmodule

/* design/mac_chain.sv */
`include "vecdot_macros.svh"

module mac_chain (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 en,
  input  vecdot_pkg::tap_vec_t ker_vec,
  input  vecdot_pkg::tap_vec_t ifm_vec,
  input  logic                 vec_strobe,
  output vecdot_pkg::acc_t     acc,
  output logic                 acc_valid
);

  // Input register, multiplier register, then one stage per tap
  localparam int TAG_DEPTH = `VD_TAPS + 2;

  vecdot_pkg::tap_vec_t ker_q;
  vecdot_pkg::tap_vec_t ifm_q;
  vecdot_pkg::product_t prod_q [`VD_TAPS];
  vecdot_pkg::acc_t     psum_q [`VD_TAPS];
  logic [TAG_DEPTH-1:0] tag_q;

  //////////////////////////////////////////////////
  // Input registers and multipliers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      ker_q <= '{default: '0};
      ifm_q <= '{default: '0};
    end else if (en) begin
      ker_q <= ker_vec;
      ifm_q <= ifm_vec;
    end
  end

  // Both operands are signed, so the full product keeps its sign
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '{default: '0};
    end else if (en) begin
      for (int i = 0; i < `VD_TAPS; i++) begin
        prod_q[i] <= ker_q[i] * ifm_q[i];
      end
    end
  end

  //////////////////////////////////////////////////
  // Cascaded adder chain
  //////////////////////////////////////////////////

  // Stage k picks up product k one cycle after stage k-1.
  // A product has to stay put until stage 8 is done with it,
  // which the 9-cycle minimum spacing of vectors guarantees
  always_ff @(posedge clk) begin
    if (reset) begin
      psum_q <= '{default: '0};
    end else if (en) begin
      psum_q[0] <= vecdot_pkg::acc_t'(prod_q[0]);
      for (int k = 1; k < `VD_TAPS; k++) begin
        psum_q[k] <= psum_q[k-1] + vecdot_pkg::acc_t'(prod_q[k]);
      end
    end
  end

  // Valid tag walks alongside the data
  always_ff @(posedge clk) begin
    if (reset) begin
      tag_q <= '0;
    end else if (en) begin
      tag_q <= {tag_q[TAG_DEPTH-2:0], vec_strobe};
    end
  end

  assign acc       = psum_q[`VD_TAPS-1];
  assign acc_valid = tag_q[TAG_DEPTH-1];

endmodule

/* design/tap_bank.sv */
`include "vecdot_macros.svh"

module tap_bank (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 en,
  input  vecdot_pkg::sample_t  din,
  input  logic                 din_valid,
  output vecdot_pkg::tap_vec_t vec,
  output logic                 vec_strobe
);

  // The ninth slot is the incoming sample itself
  localparam int SHIFT_DEPTH = `VD_TAPS - 1;

  vecdot_pkg::sample_t  shift_q [SHIFT_DEPTH];
  vecdot_pkg::tap_vec_t hold_q;
  vecdot_pkg::tap_idx_t count_q;
  logic                 accept;
  logic                 last_tap;
  logic                 strobe_q;

  assign accept   = en && din_valid;
  assign last_tap = (count_q == vecdot_pkg::tap_idx_t'(`VD_TAPS - 1));

  //////////////////////////////////////////////////
  // Serial input side
  //////////////////////////////////////////////////

  // Newest sample enters at the top, oldest drifts toward index 0
  always_ff @(posedge clk) begin
    if (reset) begin
      shift_q <= '{default: '0};
    end else if (accept) begin
      for (int i = 0; i < SHIFT_DEPTH - 1; i++) begin
        shift_q[i] <= shift_q[i+1];
      end
      shift_q[SHIFT_DEPTH-1] <= din;
    end
  end

  // Tap counter wraps after the ninth accepted sample
  always_ff @(posedge clk) begin
    if (reset) begin
      count_q <= '0;
    end else if (accept) begin
      if (last_tap) begin
        count_q <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Hold bank
  //////////////////////////////////////////////////

  // First sample of the vector lands at index 0
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_q <= '{default: '0};
    end else if (accept && last_tap) begin
      for (int i = 0; i < SHIFT_DEPTH; i++) begin
        hold_q[i] <= shift_q[i];
      end
      hold_q[`VD_TAPS-1] <= din;
    end
  end

  // One enabled cycle per completed vector
  always_ff @(posedge clk) begin
    if (reset) begin
      strobe_q <= 1'b0;
    end else if (en) begin
      strobe_q <= din_valid && last_tap;
    end
  end

  assign vec        = hold_q;
  assign vec_strobe = strobe_q;

endmodule

/* design/vecdot9.sv */
module vecdot9 (
  input  logic                clk,
  input  logic                reset,
  input  logic                en,
  input  vecdot_pkg::sample_t hin,
  input  logic                hin_valid,
  input  vecdot_pkg::sample_t xin,
  input  logic                xin_valid,
  output vecdot_pkg::sample_t dout,
  output logic                dout_valid,
  output logic                sat
);

  vecdot_pkg::tap_vec_t ker_vec;
  vecdot_pkg::tap_vec_t ifm_vec;
  logic                 vec_strobe;
  vecdot_pkg::acc_t     acc;
  logic                 acc_valid;

  //////////////////////////////////////////////////
  // Serial to parallel banks
  //////////////////////////////////////////////////

  // Kernel stays held until the next full kernel arrives
  tap_bank u_ker_bank (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .din        (hin),
    .din_valid  (hin_valid),
    .vec        (ker_vec),
    .vec_strobe ()
  );

  // Only the feature stream starts a computation
  tap_bank u_ifm_bank (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .din        (xin),
    .din_valid  (xin_valid),
    .vec        (ifm_vec),
    .vec_strobe (vec_strobe)
  );

  //////////////////////////////////////////////////
  // Multiply, accumulate and round
  //////////////////////////////////////////////////

  mac_chain u_mac (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .ker_vec    (ker_vec),
    .ifm_vec    (ifm_vec),
    .vec_strobe (vec_strobe),
    .acc        (acc),
    .acc_valid  (acc_valid)
  );

  fixed_round u_round (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .acc        (acc),
    .acc_valid  (acc_valid),
    .dout       (dout),
    .dout_valid (dout_valid),
    .sat        (sat)
  );

endmodule

/* design/vecdot_pkg.sv */
`include "vecdot_macros.svh"

package vecdot_pkg;

  // One input sample, kernel tap or rounded output word
  typedef logic signed [`VD_IN_WIDTH-1:0] sample_t;

  // Product of two samples, 20 fraction bits
  typedef logic signed [2*`VD_IN_WIDTH-1:0] product_t;

  // Running sum of the nine products
  typedef logic signed [`VD_ACC_WIDTH-1:0] acc_t;

  // Position inside a vector, 0 to 8
  typedef logic [`VD_IDX_WIDTH-1:0] tap_idx_t;

  // Whole vector as carried between modules
  typedef sample_t tap_vec_t [`VD_TAPS];

endpackage

/* dv/tb_clock.sv */
module tb_clock (
  output logic clk
);

  // Period of 40
  localparam int HALF_PERIOD = 20;

  initial begin
    clk = 1'b0;
    forever begin
      #HALF_PERIOD clk = ~clk;
    end
  end

endmodule

/* dv/vecdot9_asserts.sv */
module vecdot9_asserts (
  input logic clk,
  input logic reset,
  input logic en,
  input logic dout_valid,
  input logic sat
);

  //////////////////////////////////////////////////
  // Output pulse rules
  //////////////////////////////////////////////////

  // One result per pulse, even across en-low stretches
  single_pulse: assert property (
    @(posedge clk) disable iff (reset) (en && dout_valid) |=> !dout_valid
  ) else $error("dout_valid high in two consecutive enabled cycles");

  // Saturation flag only qualified by a valid result
  sat_qualified: assert property (
    @(posedge clk) disable iff (reset) sat |-> dout_valid
  ) else $error("sat high without dout_valid");

  //////////////////////////////////////////////////
  // Reset
  //////////////////////////////////////////////////

  quiet_in_reset: assert property (
    @(posedge clk) reset |=> !dout_valid
  ) else $error("dout_valid high while reset is asserted");

endmodule

bind vecdot9 vecdot9_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .en         (en),
  .dout_valid (dout_valid),
  .sat        (sat)
);

/* dv/vecdot9_tb.sv */
`include "vecdot_macros.svh"

module vecdot9_tb;

  localparam int NUM_ROWS       = 24;
  localparam int FIXED_ROWS     = 10;
  localparam int LATENCY        = 13;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 30 + 100;

  logic                clk;
  logic                reset;
  logic                en;
  vecdot_pkg::sample_t hin;
  logic                hin_valid;
  vecdot_pkg::sample_t xin;
  logic                xin_valid;
  vecdot_pkg::sample_t dout;
  logic                dout_valid;
  logic                sat;

  // Stimulus table with expected fields filled before the run
  logic                row_new_ker [NUM_ROWS];
  vecdot_pkg::sample_t row_ker     [NUM_ROWS][`VD_TAPS];
  vecdot_pkg::sample_t row_ifm     [NUM_ROWS][`VD_TAPS];
  int                  row_gap     [NUM_ROWS];
  logic [`VD_TAPS:0]   row_en_mask [NUM_ROWS];
  vecdot_pkg::sample_t exp_dout    [NUM_ROWS];
  logic                exp_sat     [NUM_ROWS];

  // Vectors in flight and bookkeeping for the monitor
  int pend_row[$];
  int pend_edge[$];
  int en_edges     = 0;
  int feat_cnt     = 0;
  int next_row     = 0;
  int results_done = 0;
  int cycle_count  = 0;

  tb_clock u_clock (
    .clk (clk)
  );

  vecdot9 u_dut (
    .clk        (clk),
    .reset      (reset),
    .en         (en),
    .hin        (hin),
    .hin_valid  (hin_valid),
    .xin        (xin),
    .xin_valid  (xin_valid),
    .dout       (dout),
    .dout_valid (dout_valid),
    .sat        (sat)
  );

  //////////////////////////////////////////////////
  // Error reporting
  //////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic expect_value(input string name, input longint exp_v, input longint got_v);
    string line;
    assert (exp_v == got_v) else begin
      line = $sformatf("ERROR %0t %s expected %0d got %0d", $time, name, exp_v, got_v);
      report_failure(line);
    end
  endtask

  //////////////////////////////////////////////////
  // Table and reference model
  //////////////////////////////////////////////////

  // Two leading taps plus a fill value for the other seven
  task automatic fill_row(input int r, input logic new_ker, input int k0, input int k1,
                          input int kfill, input int x0, input int x1, input int xfill,
                          input int gap, input logic [`VD_TAPS:0] en_mask);
    for (int i = 0; i < `VD_TAPS; i++) begin
      if (new_ker) begin
        row_ker[r][i] = vecdot_pkg::sample_t'((i == 0) ? k0 : (i == 1) ? k1 : kfill);
      end else begin
        row_ker[r][i] = row_ker[r-1][i];
      end
      row_ifm[r][i] = vecdot_pkg::sample_t'((i == 0) ? x0 : (i == 1) ? x1 : xfill);
    end
    row_new_ker[r] = new_ker;
    row_gap[r]     = gap;
    row_en_mask[r] = en_mask;
  endtask

  // Exact sum, add half an LSB, drop 10 fraction bits, clamp
  function automatic void model_dot(input int r);
    longint sum;
    longint q;
    sum = 0;
    for (int i = 0; i < `VD_TAPS; i++) begin
      sum = sum + longint'(row_ker[r][i]) * longint'(row_ifm[r][i]);
    end
    q = (sum + 512) >>> 10;
    exp_sat[r] = 1'b1;
    if (q > 32767) begin
      exp_dout[r] = 16'sh7fff;
    end else if (q < -32768) begin
      exp_dout[r] = 16'sh8000;
    end else begin
      exp_dout[r] = vecdot_pkg::sample_t'(q);
      exp_sat[r]  = 1'b0;
    end
  endfunction

  task automatic build_table();
    int shift;
    // Rounding around half an LSB with a unit kernel held over four vectors
    fill_row(0, 1'b1, 1, 0, 0, 511, 0, 0, 0, 10'b0000000000);
    fill_row(1, 1'b0, 0, 0, 0, 512, 0, 0, 0, 10'b0000010010);
    fill_row(2, 1'b0, 0, 0, 0, -512, 0, 0, 2, 10'b0000000000);
    fill_row(3, 1'b0, 0, 0, 0, -513, 0, 0, 0, 10'b1000000001);
    // Far beyond both clamp limits
    fill_row(4, 1'b1, 32767, 32767, 32767, 32767, 32767, 32767, 0, 10'b0000000000);
    fill_row(5, 1'b0, 0, 0, 0, -32768, -32768, -32768, 1, 10'b1111111111);
    // Just inside and just outside both limits with a kernel of 1.0
    fill_row(6, 1'b1, 1024, 1024, 0, 32767, 0, 0, 0, 10'b0000000000);
    fill_row(7, 1'b0, 0, 0, 0, 32767, 1, 0, 0, 10'b0100000000);
    fill_row(8, 1'b0, 0, 0, 0, -32768, 0, 0, 0, 10'b0000000000);
    fill_row(9, 1'b0, 0, 0, 0, -32768, -1, 0, 0, 10'b0000000000);
    for (int r = FIXED_ROWS; r < NUM_ROWS; r++) begin
      shift          = 2 + $urandom_range(0, 4);
      row_new_ker[r] = ($urandom_range(0, 2) == 0);
      for (int i = 0; i < `VD_TAPS; i++) begin
        if (row_new_ker[r]) begin
          row_ker[r][i] = vecdot_pkg::sample_t'($urandom) >>> shift;
        end else begin
          row_ker[r][i] = row_ker[r-1][i];
        end
        row_ifm[r][i] = vecdot_pkg::sample_t'($urandom) >>> shift;
      end
      row_gap[r]     = (r % 3 == 0) ? int'($urandom_range(1, 3)) : 0;
      row_en_mask[r] = (r % 2 == 1) ? 10'($urandom & $urandom) : '0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      model_dot(r);
    end
  endtask

  //////////////////////////////////////////////////
  // Driving
  //////////////////////////////////////////////////

  task automatic drive_step(input logic e, input logic hv, input vecdot_pkg::sample_t h,
                            input logic xv, input vecdot_pkg::sample_t x);
    @(posedge clk);
    #5;
    en        = e;
    hin_valid = hv;
    hin       = h;
    xin_valid = xv;
    xin       = x;
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #5;
    reset     = 1'b1;
    en        = 1'b1;
    hin_valid = 1'b0;
    xin_valid = 1'b0;
    repeat (8) @(posedge clk);
    #5;
    reset = 1'b0;
  endtask

  task automatic check_idle_outputs();
    expect_value("dout_valid", 0, dout_valid);
    expect_value("sat", 0, sat);
  endtask

  // Strobes with en low carry junk that must be ignored
  task automatic drive_row(input int r);
    for (int i = 0; i < `VD_TAPS; i++) begin
      if (row_en_mask[r][i]) begin
        drive_step(1'b0, row_new_ker[r], vecdot_pkg::sample_t'($urandom), 1'b1,
                   vecdot_pkg::sample_t'($urandom));
      end
      drive_step(1'b1, row_new_ker[r], row_ker[r][i], 1'b1, row_ifm[r][i]);
    end
    if (row_en_mask[r][`VD_TAPS]) begin
      repeat (3) drive_step(1'b0, 1'b0, '0, 1'b0, '0);
    end
    repeat (row_gap[r]) drive_step(1'b1, 1'b0, '0, 1'b0, '0);
  endtask

  //////////////////////////////////////////////////
  // Monitor with latency counted in enabled edges
  //////////////////////////////////////////////////

  always @(posedge clk) begin : monitor
    int row;
    int edge_at_ninth;
    if (reset) begin
      feat_cnt = 0;
    end else if (en) begin
      if (dout_valid) begin
        assert (pend_row.size() > 0)
          else report_failure("dout_valid pulsed with no complete feature vector in flight");
        row           = pend_row.pop_front();
        edge_at_ninth = pend_edge.pop_front();
        expect_value("latency", LATENCY, en_edges - edge_at_ninth);
        expect_value("dout", exp_dout[row], dout);
        expect_value("sat", exp_sat[row], sat);
        results_done = results_done + 1;
      end
      if (xin_valid) begin
        feat_cnt = feat_cnt + 1;
        if (feat_cnt == `VD_TAPS) begin
          pend_row.push_back(next_row);
          pend_edge.push_back(en_edges);
          next_row = next_row + 1;
          feat_cnt = 0;
        end
      end
      en_edges = en_edges + 1;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Timeout after %0d cycles, outputs stopped arriving",
                               cycle_count));
    end
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    reset     = 1'b1;
    en        = 1'b0;
    hin       = '0;
    hin_valid = 1'b0;
    xin       = '0;
    xin_valid = 1'b0;
    void'($urandom(32'hae1c));
    build_table();

    apply_reset();
    check_idle_outputs();

    // A kernel and eight feature samples must not produce a result
    for (int i = 0; i < `VD_TAPS; i++) begin
      drive_step(1'b1, 1'b1, vecdot_pkg::sample_t'($urandom), 1'b0, '0);
    end
    for (int i = 0; i < `VD_TAPS - 1; i++) begin
      drive_step(1'b1, 1'b0, '0, 1'b1, vecdot_pkg::sample_t'($urandom));
    end
    repeat (20) drive_step(1'b1, 1'b0, '0, 1'b0, '0);

    apply_reset();
    check_idle_outputs();

    for (int r = 0; r < NUM_ROWS; r++) begin
      drive_row(r);
    end
    while (results_done < NUM_ROWS) begin
      drive_step(1'b1, 1'b0, '0, 1'b0, '0);
    end
    repeat (4) drive_step(1'b1, 1'b0, '0, 1'b0, '0);

    if (results_done == NUM_ROWS && pend_row.size() == 0) begin
      $display("Result: PASSED");
    end else begin
      report_failure("Run ended with results missing or extra");
    end
    $finish;
  end

endmodule

/* include/vecdot_macros.svh */
`ifndef VECDOT_MACROS_SVH
`define VECDOT_MACROS_SVH

//////////////////////////////////////////////////
// Sample format, 16 bits with 10 fraction bits
//////////////////////////////////////////////////

`define VD_IN_WIDTH 16
`define VD_IN_FRAC 10

//////////////////////////////////////////////////
// Vector length and derived widths
//////////////////////////////////////////////////

`define VD_TAPS 9
// Full product width plus 9 guard bits for the sum
`define VD_ACC_WIDTH 41
`define VD_IDX_WIDTH 4

`endif

/* run.sh */
#!/bin/sh
# Build and run the vecdot9 testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module vecdot9_tb \
  -o vecdot9_sim

# The exit status of tee is used here, so the log decides the outcome
./obj_dir/vecdot9_sim 2>&1 | tee sim.log

if grep -q "^Result: PASSED$" sim.log; then
  echo "vecdot9 simulation passed"
  exit 0
else
  echo "vecdot9 simulation did not pass, see sim.log"
  exit 1
fi

/* verilog.f */
+incdir+include
design/vecdot_pkg.sv
design/tap_bank.sv
design/mac_chain.sv
design/fixed_round.sv
design/vecdot9.sv
dv/tb_clock.sv
dv/vecdot9_asserts.sv
dv/vecdot9_tb.sv
